//--- flist.f
+incdir+rtl
rtl/axi_burst_pkg.sv
rtl/dcache_req_pkg.sv
rtl/beat_counter.sv
rtl/evict_line_buffer.sv
rtl/refill_line_buffer.sv
rtl/burst_ctrl_fsm.sv
rtl/dcache_axi_bridge.sv
bench/axi_mem_model.sv
bench/tb_dcache_axi_bridge.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_dcache_axi_bridge
RTL_TOP    := dcache_axi_bridge
FLIST      := flist.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_dcache_axi_bridge.sv
`timescale 1ns/1ps
`include "dcache_axi_config.svh"

module tb_dcache_axi_bridge;

    localparam int MEM_BYTES  = 1024;
    localparam int LINE_BYTES = `DCA_LINE_W / 8;
    localparam int N_LINES    = MEM_BYTES / LINE_BYTES;
    localparam int N_TRANS    = 32;   // all transactions over all tests
    localparam int CLK_PERIOD = 4;

    logic clock;
    logic reset;
    logic stall_en;

    logic                        refill_valid, refill_ready, refill_done;
    dcache_req_pkg::refill_req_t refill_req;
    dcache_req_pkg::refill_rsp_t refill_rsp;
    logic                        evict_valid, evict_ready, evict_done;
    dcache_req_pkg::evict_req_t  evict_req;
    dcache_req_pkg::evict_rsp_t  evict_rsp;

    axi_burst_pkg::axi_ax_t ar, aw;
    axi_burst_pkg::axi_r_t  r;
    axi_burst_pkg::axi_w_t  w;
    axi_burst_pkg::axi_b_t  b;
    logic ar_valid, ar_ready, r_valid, r_ready, aw_valid, aw_ready;
    logic w_valid, w_ready, b_valid, b_ready;

    int errors;
    int w_beats;   // W beats since the last AW
    logic [7:0] ref_mem [0:MEM_BYTES-1];

    dcache_axi_bridge i_dut (
        .clock          (clock),
        .reset          (reset),
        .refill_valid_i (refill_valid),
        .refill_req_i   (refill_req),
        .refill_ready_o (refill_ready),
        .refill_done_o  (refill_done),
        .refill_rsp_o   (refill_rsp),
        .evict_valid_i  (evict_valid),
        .evict_req_i    (evict_req),
        .evict_ready_o  (evict_ready),
        .evict_done_o   (evict_done),
        .evict_rsp_o    (evict_rsp),
        .ar_o           (ar),
        .ar_valid_o     (ar_valid),
        .ar_ready_i     (ar_ready),
        .r_i            (r),
        .r_valid_i      (r_valid),
        .r_ready_o      (r_ready),
        .aw_o           (aw),
        .aw_valid_o     (aw_valid),
        .aw_ready_i     (aw_ready),
        .w_o            (w),
        .w_valid_o      (w_valid),
        .w_ready_i      (w_ready),
        .b_i            (b),
        .b_valid_i      (b_valid),
        .b_ready_o      (b_ready)
    );

    axi_mem_model #(.MEM_BYTES(MEM_BYTES)) i_mem (
        .clock_i    (clock),
        .reset_i    (reset),
        .stall_en_i (stall_en),
        .ar_i       (ar),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .r_o        (r),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready),
        .aw_i       (aw),
        .aw_valid_i (aw_valid),
        .aw_ready_o (aw_ready),
        .w_i        (w),
        .w_valid_i  (w_valid),
        .w_ready_o  (w_ready),
        .b_o        (b),
        .b_valid_o  (b_valid),
        .b_ready_i  (b_ready)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic check(string name, logic [`DCA_LINE_W-1:0] exp,
                         logic [`DCA_LINE_W-1:0] act);
        assert (act === exp) else begin
            errors++;
            $display("Error %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    // one line is four 8-byte beats in an INCR burst
    task automatic verify_burst_shape(string name, axi_burst_pkg::axi_ax_t ax);
        check({name, " len"}, 3, ax.len);
        check({name, " size"}, 3, ax.size);
        check({name, " burst"}, 1, ax.burst);
    endtask

    always @(posedge clock) begin
        if (ar_valid && ar_ready) begin
            verify_burst_shape("ar", ar);
        end
        if (aw_valid && aw_ready) begin
            verify_burst_shape("aw", aw);
            w_beats = 0;
        end
        if (w_valid && w_ready) begin
            check("w last", (w_beats == 3), w.last);   // last only on beat 3
            w_beats++;
        end
    end

    function automatic dcache_req_pkg::line_t rand_line();
        dcache_req_pkg::line_t l;
        for (int i = 0; i < `DCA_LINE_W / 32; i++) l[i*32 +: 32] = $urandom;
        return l;
    endfunction

    // expected line with byte 0 of the line in the low bits
    function automatic dcache_req_pkg::line_t ref_line(logic [63:0] addr);
        dcache_req_pkg::line_t l;
        for (int i = 0; i < LINE_BYTES; i++) l[i*8 +: 8] = ref_mem[int'(addr) + i];
        return l;
    endfunction

    // same strobe on each beat and nothing written out of range
    task automatic ref_write(logic [63:0] addr, dcache_req_pkg::line_t data,
                             dcache_req_pkg::byte_mask_t mask);
        if (addr < MEM_BYTES) begin
            for (int i = 0; i < LINE_BYTES; i++) begin
                if (mask[i % `DCA_STRB_W]) ref_mem[int'(addr) + i] = data[i*8 +: 8];
            end
        end
    endtask

    function automatic axi_burst_pkg::axi_resp_t exp_resp(logic [63:0] addr);
        return (addr < MEM_BYTES) ? axi_burst_pkg::RESP_OKAY : axi_burst_pkg::RESP_SLVERR;
    endfunction

    task automatic check_memory(string name);
        for (int a = 0; a < MEM_BYTES; a++) begin
            check($sformatf("%s mem[%0d]", name, a), ref_mem[a], i_mem.mem[a]);
        end
    endtask

    // runs from a falling edge to the falling edge with the done pulse
    task automatic refill(logic [63:0] addr, output dcache_req_pkg::refill_rsp_t rsp);
        refill_req.addr = addr;
        refill_valid    = 1'b1;
        while (!refill_ready) @(negedge clock);
        @(negedge clock);             // request taken on the edge in between
        refill_valid = 1'b0;
        while (!refill_done) @(negedge clock);
        rsp = refill_rsp;
    endtask

    task automatic evict(logic [63:0] addr, dcache_req_pkg::line_t data,
                         dcache_req_pkg::byte_mask_t mask,
                         output dcache_req_pkg::evict_rsp_t rsp);
        evict_req.addr = addr;
        evict_req.data = data;
        evict_req.mask = mask;
        evict_valid    = 1'b1;
        while (!evict_ready) @(negedge clock);
        @(negedge clock);
        evict_valid = 1'b0;
        while (!evict_done) @(negedge clock);
        rsp = evict_rsp;
    endtask

    task automatic test_reset();
        check("reset ar_valid", 0, ar_valid);
        check("reset r_ready", 0, r_ready);
        check("reset aw_valid", 0, aw_valid);
        check("reset w_valid", 0, w_valid);
        check("reset b_ready", 0, b_ready);
        check("reset refill_done", 0, refill_done);
        check("reset evict_done", 0, evict_done);
        check("reset refill_ready", 1, refill_ready);
        check("reset evict_ready", 1, evict_ready);
    endtask

    task automatic test_refill_preloaded();
        logic [63:0] addrs [4] = '{0, 32, 480, MEM_BYTES - LINE_BYTES};
        dcache_req_pkg::refill_rsp_t rsp;
        for (int i = 0; i < 4; i++) begin
            refill(addrs[i], rsp);
            check("refill_preloaded line", ref_line(addrs[i]), rsp.data);
            check("refill_preloaded resp", axi_burst_pkg::RESP_OKAY, rsp.resp);
        end
    endtask

    task automatic test_evict_refill();
        dcache_req_pkg::line_t       data;
        dcache_req_pkg::refill_rsp_t rrsp;
        dcache_req_pkg::evict_rsp_t  ersp;
        data = rand_line();
        evict(64, data, 8'ha5, ersp);
        ref_write(64, data, 8'ha5);
        check("evict_refill resp", axi_burst_pkg::RESP_OKAY, ersp.resp);
        refill(64, rrsp);
        check("evict_refill line", ref_line(64), rrsp.data);
    endtask

    task automatic test_random_stalls();
        logic [63:0]                 addr;
        dcache_req_pkg::line_t       data;
        dcache_req_pkg::byte_mask_t  mask;
        dcache_req_pkg::refill_rsp_t rrsp;
        dcache_req_pkg::evict_rsp_t  ersp;
        stall_en = 1'b1;
        for (int n = 0; n < 20; n++) begin
            addr = 64'($urandom_range(N_LINES - 1) * LINE_BYTES);
            if ($urandom_range(1) == 1) begin
                data = rand_line();
                mask = 8'($urandom);
                evict(addr, data, mask, ersp);
                ref_write(addr, data, mask);
                check("random_stalls evict resp", axi_burst_pkg::RESP_OKAY, ersp.resp);
            end else begin
                refill(addr, rrsp);
                check("random_stalls refill line", ref_line(addr), rrsp.data);
                check("random_stalls refill resp", axi_burst_pkg::RESP_OKAY, rrsp.resp);
            end
        end
        stall_en = 1'b0;
        check_memory("random_stalls");
    endtask

    task automatic test_concurrent();
        dcache_req_pkg::line_t       data, exp;
        dcache_req_pkg::refill_rsp_t rrsp;
        dcache_req_pkg::evict_rsp_t  ersp;
        data = rand_line();
        exp  = ref_line(256);         // different line from the evict
        fork
            evict(128, data, 8'h3c, ersp);
            refill(256, rrsp);
        join
        ref_write(128, data, 8'h3c);
        check("concurrent evict resp", axi_burst_pkg::RESP_OKAY, ersp.resp);
        check("concurrent refill resp", axi_burst_pkg::RESP_OKAY, rrsp.resp);
        check("concurrent refill line", exp, rrsp.data);
        check_memory("concurrent");
    endtask

    task automatic test_out_of_range();
        logic [63:0] addrs [2] = '{MEM_BYTES, 64'h0000_0001_0000_0000};
        dcache_req_pkg::refill_rsp_t rrsp;
        dcache_req_pkg::evict_rsp_t  ersp;
        for (int i = 0; i < 2; i++) begin
            refill(addrs[i], rrsp);
            check("out_of_range refill resp", exp_resp(addrs[i]), rrsp.resp);
            evict(addrs[i], rand_line(), 8'hff, ersp);
            check("out_of_range evict resp", exp_resp(addrs[i]), ersp.resp);
        end
        check_memory("out_of_range");
    endtask

    initial begin
        void'($urandom(32'h339b));
        errors       = 0;
        w_beats      = 0;
        clock        = 1'b0;
        reset        = 1'b0;
        stall_en     = 1'b0;
        refill_valid = 1'b0;
        refill_req   = '0;
        evict_valid  = 1'b0;
        evict_req    = '0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        for (int a = 0; a < MEM_BYTES; a++) ref_mem[a] = i_mem.mem[a];  // preload snapshot
        @(negedge clock);
        test_reset();
        test_refill_preloaded();
        test_evict_refill();
        test_random_stalls();
        test_concurrent();
        test_out_of_range();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // budget of 200 cycles per transaction plus reset
    initial begin
        #(CLK_PERIOD * (10 + 200 * N_TRANS));
        $display("watchdog expired before the tests finished, a transaction hung");
        $display("Regression failed");
        $finish;
    end

endmodule

//--- bench/axi_mem_model.sv
`timescale 1ns/1ps
`include "dcache_axi_config.svh"

module axi_mem_model #(
    parameter int MEM_BYTES = 1024    // accesses at or above this address get SLVERR
) (
    input  logic                   clock_i,
    input  logic                   reset_i,
    input  logic                   stall_en_i,
    input  axi_burst_pkg::axi_ax_t ar_i,
    input  logic                   ar_valid_i,
    output logic                   ar_ready_o,
    output axi_burst_pkg::axi_r_t  r_o,
    output logic                   r_valid_o,
    input  logic                   r_ready_i,
    input  axi_burst_pkg::axi_ax_t aw_i,
    input  logic                   aw_valid_i,
    output logic                   aw_ready_o,
    input  axi_burst_pkg::axi_w_t  w_i,
    input  logic                   w_valid_i,
    output logic                   w_ready_o,
    output axi_burst_pkg::axi_b_t  b_o,
    output logic                   b_valid_o,
    input  logic                   b_ready_i
);

    logic [7:0] mem [0:MEM_BYTES-1];

    logic ar_hs, r_hs, aw_hs, w_hs, b_hs;
    axi_burst_pkg::axi_ax_t ar_q, aw_q;
    axi_burst_pkg::axi_w_t  w_q;

    logic [`DCA_ADDR_W-1:0] rd_addr, wr_addr, beat_addr;
    int   rd_beat, wr_beat;
    logic rd_active, wr_active, wr_err, b_pend;

    // initial contents, every byte a function of its full address
    initial begin
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem[a] = 8'(a * 37 + (a >> 8) + 8'h5a);
        end
    end

    // about one cycle in four held back when stalls are on
    function automatic logic go();
        return !stall_en_i || ($urandom_range(3) != 0);
    endfunction

    function automatic logic beat_ok(logic [`DCA_ADDR_W-1:0] addr);
        return (addr + 7) < MEM_BYTES;
    endfunction

    // handshakes seen on the rising edge, acted on at the falling edge
    always @(posedge clock_i or negedge reset_i) begin
        if (!reset_i) begin
            ar_hs <= 1'b0;
            r_hs  <= 1'b0;
            aw_hs <= 1'b0;
            w_hs  <= 1'b0;
            b_hs  <= 1'b0;
        end else begin
            ar_hs <= ar_valid_i && ar_ready_o;
            r_hs  <= r_valid_o && r_ready_i;
            aw_hs <= aw_valid_i && aw_ready_o;
            w_hs  <= w_valid_i && w_ready_o;
            b_hs  <= b_valid_o && b_ready_i;
            ar_q  <= ar_i;
            aw_q  <= aw_i;
            w_q   <= w_i;
        end
    end

    always @(negedge clock_i or negedge reset_i) begin
        if (!reset_i) begin
            ar_ready_o = 1'b0;
            r_valid_o  = 1'b0;
            r_o        = '0;
            aw_ready_o = 1'b0;
            w_ready_o  = 1'b0;
            b_valid_o  = 1'b0;
            b_o        = '0;
            rd_active  = 1'b0;
            wr_active  = 1'b0;
            wr_err     = 1'b0;
            b_pend     = 1'b0;
            rd_beat    = 0;
            wr_beat    = 0;
        end else begin
            // read burst
            if (ar_hs) begin
                rd_addr   = ar_q.addr;
                rd_beat   = 0;
                rd_active = 1'b1;
            end
            if (r_hs) begin
                r_valid_o = 1'b0;
                rd_beat   = rd_beat + 1;
                if (rd_beat == `DCA_BEATS) rd_active = 1'b0;
            end
            if (rd_active && !r_valid_o && go()) begin
                beat_addr = rd_addr + 8 * rd_beat;
                r_o.last  = (rd_beat == `DCA_BEATS - 1);
                r_o.data  = '0;
                r_o.resp  = axi_burst_pkg::RESP_SLVERR;
                if (beat_ok(beat_addr)) begin
                    r_o.resp = axi_burst_pkg::RESP_OKAY;
                    for (int i = 0; i < `DCA_STRB_W; i++) begin
                        r_o.data[i*8 +: 8] = mem[beat_addr + i];
                    end
                end
                r_valid_o = 1'b1;
            end
            ar_ready_o = !rd_active && go();

            // write burst
            if (aw_hs) begin
                wr_addr   = aw_q.addr;
                wr_beat   = 0;
                wr_err    = 1'b0;
                wr_active = 1'b1;
            end
            if (w_hs) begin
                beat_addr = wr_addr + 8 * wr_beat;
                if (beat_ok(beat_addr)) begin
                    for (int i = 0; i < `DCA_STRB_W; i++) begin
                        if (w_q.strb[i]) mem[beat_addr + i] = w_q.data[i*8 +: 8];
                    end
                end else begin
                    wr_err = 1'b1;        // nothing written out of range
                end
                wr_beat = wr_beat + 1;
                if (w_q.last) b_pend = 1'b1;
            end
            if (b_hs) begin
                b_valid_o = 1'b0;
                wr_active = 1'b0;
            end
            if (b_pend && go()) begin
                b_o.resp  = wr_err ? axi_burst_pkg::RESP_SLVERR : axi_burst_pkg::RESP_OKAY;
                b_valid_o = 1'b1;
                b_pend    = 1'b0;
            end
            aw_ready_o = !wr_active && go();
            w_ready_o  = wr_active && (wr_beat < `DCA_BEATS) && go();
        end
    end

endmodule

//--- rtl/dcache_axi_bridge.sv
`timescale 1ns/1ps

module dcache_axi_bridge (
    input  logic                        clock,
    input  logic                        reset,
    // cache side
    input  logic                        refill_valid_i,
    input  dcache_req_pkg::refill_req_t refill_req_i,
    output logic                        refill_ready_o,
    output logic                        refill_done_o,
    output dcache_req_pkg::refill_rsp_t refill_rsp_o,
    input  logic                        evict_valid_i,
    input  dcache_req_pkg::evict_req_t  evict_req_i,
    output logic                        evict_ready_o,
    output logic                        evict_done_o,
    output dcache_req_pkg::evict_rsp_t  evict_rsp_o,
    // AXI side
    output axi_burst_pkg::axi_ax_t      ar_o,
    output logic                        ar_valid_o,
    input  logic                        ar_ready_i,
    input  axi_burst_pkg::axi_r_t       r_i,
    input  logic                        r_valid_i,
    output logic                        r_ready_o,
    output axi_burst_pkg::axi_ax_t      aw_o,
    output logic                        aw_valid_o,
    input  logic                        aw_ready_i,
    output axi_burst_pkg::axi_w_t       w_o,
    output logic                        w_valid_o,
    input  logic                        w_ready_i,
    input  axi_burst_pkg::axi_b_t       b_i,
    input  logic                        b_valid_i,
    output logic                        b_ready_o
);

    logic wr_capture, wr_advance, wr_last_beat;
    logic rd_capture, rd_advance, rd_last_beat;
    dcache_req_pkg::beat_idx_t wr_idx, rd_idx;

    burst_ctrl_fsm u_fsm (
        .clock_i        (clock),
        .reset_i        (reset),
        .refill_valid_i (refill_valid_i),
        .evict_valid_i  (evict_valid_i),
        .refill_ready_o (refill_ready_o),
        .evict_ready_o  (evict_ready_o),
        .ar_valid_o     (ar_valid_o),
        .ar_ready_i     (ar_ready_i),
        .r_valid_i      (r_valid_i),
        .r_last_i       (r_i.last),
        .r_ready_o      (r_ready_o),
        .aw_valid_o     (aw_valid_o),
        .aw_ready_i     (aw_ready_i),
        .w_valid_o      (w_valid_o),
        .w_ready_i      (w_ready_i),
        .b_valid_i      (b_valid_i),
        .b_ready_o      (b_ready_o),
        .wr_last_beat_i (wr_last_beat),
        .rd_last_beat_i (rd_last_beat),
        .wr_capture_o   (wr_capture),
        .wr_advance_o   (wr_advance),
        .rd_capture_o   (rd_capture),
        .rd_advance_o   (rd_advance),
        .refill_done_o  (refill_done_o),
        .evict_done_o   (evict_done_o)
    );

    beat_counter u_wr_cnt (
        .clock_i     (clock),
        .reset_i     (reset),
        .clear_i     (wr_capture),
        .advance_i   (wr_advance),
        .beat_idx_o  (wr_idx),
        .last_beat_o (wr_last_beat)
    );

    beat_counter u_rd_cnt (
        .clock_i     (clock),
        .reset_i     (reset),
        .clear_i     (rd_capture),
        .advance_i   (rd_advance),
        .beat_idx_o  (rd_idx),
        .last_beat_o (rd_last_beat)
    );

    evict_line_buffer u_evict_buf (
        .clock_i     (clock),
        .capture_i   (wr_capture),
        .req_i       (evict_req_i),
        .beat_idx_i  (wr_idx),
        .last_beat_i (wr_last_beat),
        .b_en_i      (b_valid_i),     // B only arrives in WR_RESP
        .b_i         (b_i),
        .aw_o        (aw_o),
        .w_o         (w_o),
        .rsp_o       (evict_rsp_o)
    );

    refill_line_buffer u_refill_buf (
        .clock_i    (clock),
        .reset_i    (reset),
        .capture_i  (rd_capture),
        .req_i      (refill_req_i),
        .beat_en_i  (rd_advance),
        .beat_idx_i (rd_idx),
        .r_i        (r_i),
        .ar_o       (ar_o),
        .rsp_o      (refill_rsp_o)
    );

endmodule

//--- rtl/burst_ctrl_fsm.sv
`timescale 1ns/1ps

module burst_ctrl_fsm (
    input  logic clock_i,
    input  logic reset_i,
    input  logic refill_valid_i,
    input  logic evict_valid_i,
    output logic refill_ready_o,
    output logic evict_ready_o,
    output logic ar_valid_o,
    input  logic ar_ready_i,
    input  logic r_valid_i,
    input  logic r_last_i,
    output logic r_ready_o,
    output logic aw_valid_o,
    input  logic aw_ready_i,
    output logic w_valid_o,
    input  logic w_ready_i,
    input  logic b_valid_i,
    output logic b_ready_o,
    input  logic wr_last_beat_i,
    input  logic rd_last_beat_i,
    output logic wr_capture_o,
    output logic wr_advance_o,
    output logic rd_capture_o,
    output logic rd_advance_o,
    output logic refill_done_o,
    output logic evict_done_o
);

    dcache_req_pkg::wr_state_e wr_state_q, wr_state_d;
    dcache_req_pkg::rd_state_e rd_state_q, rd_state_d;

    always_ff @(posedge clock_i or negedge reset_i) begin
        if (!reset_i) begin
            wr_state_q    <= dcache_req_pkg::WR_IDLE;
            rd_state_q    <= dcache_req_pkg::RD_IDLE;
            evict_done_o  <= 1'b0;
            refill_done_o <= 1'b0;
        end else begin
            wr_state_q    <= wr_state_d;
            rd_state_q    <= rd_state_d;
            evict_done_o  <= b_valid_i && b_ready_o;    // one cycle after B
            refill_done_o <= rd_advance_o && r_last_i;  // one cycle after last R
        end
    end

    // write direction
    always_comb begin
        wr_state_d = wr_state_q;
        case (wr_state_q)
            dcache_req_pkg::WR_IDLE: if (evict_valid_i) wr_state_d = dcache_req_pkg::WR_ADDR;
            dcache_req_pkg::WR_ADDR: if (aw_ready_i) wr_state_d = dcache_req_pkg::WR_DATA;
            dcache_req_pkg::WR_DATA: begin
                if (wr_advance_o && wr_last_beat_i) wr_state_d = dcache_req_pkg::WR_RESP;
            end
            dcache_req_pkg::WR_RESP: if (b_valid_i) wr_state_d = dcache_req_pkg::WR_IDLE;
            default: wr_state_d = dcache_req_pkg::WR_IDLE;
        endcase
    end

    assign evict_ready_o = (wr_state_q == dcache_req_pkg::WR_IDLE);
    assign aw_valid_o    = (wr_state_q == dcache_req_pkg::WR_ADDR);
    assign w_valid_o     = (wr_state_q == dcache_req_pkg::WR_DATA);
    assign b_ready_o     = (wr_state_q == dcache_req_pkg::WR_RESP);
    assign wr_capture_o  = evict_valid_i && evict_ready_o;
    assign wr_advance_o  = w_valid_o && w_ready_i;

    // read direction, runs beside the write side
    always_comb begin
        rd_state_d = rd_state_q;
        case (rd_state_q)
            dcache_req_pkg::RD_IDLE: if (refill_valid_i) rd_state_d = dcache_req_pkg::RD_ADDR;
            dcache_req_pkg::RD_ADDR: if (ar_ready_i) rd_state_d = dcache_req_pkg::RD_DATA;
            dcache_req_pkg::RD_DATA: if (rd_advance_o && r_last_i) rd_state_d = dcache_req_pkg::RD_IDLE;
            default: rd_state_d = dcache_req_pkg::RD_IDLE;
        endcase
    end

    assign refill_ready_o = (rd_state_q == dcache_req_pkg::RD_IDLE);
    assign ar_valid_o     = (rd_state_q == dcache_req_pkg::RD_ADDR);
    assign r_ready_o      = (rd_state_q == dcache_req_pkg::RD_DATA);
    assign rd_capture_o   = refill_valid_i && refill_ready_o;
    assign rd_advance_o   = r_valid_i && r_ready_o;

    a_aw_hold: assert property (@(posedge clock_i) disable iff (!reset_i)
        aw_valid_o && !aw_ready_i |=> aw_valid_o);

    a_ar_hold: assert property (@(posedge clock_i) disable iff (!reset_i)
        ar_valid_o && !ar_ready_i |=> ar_valid_o);

    // slave last flag must line up with our beat count
    a_r_last_terminal: assert property (@(posedge clock_i) disable iff (!reset_i)
        rd_advance_o && r_last_i |-> rd_last_beat_i);

    // evict response is taken on B valid alone, so B may only show up while waiting
    a_b_in_resp: assert property (@(posedge clock_i) disable iff (!reset_i)
        b_valid_i |-> b_ready_o);

endmodule

//--- rtl/refill_line_buffer.sv
`timescale 1ns/1ps
`include "dcache_axi_config.svh"

module refill_line_buffer (
    input  logic                        clock_i,
    input  logic                        reset_i,
    input  logic                        capture_i,
    input  dcache_req_pkg::refill_req_t req_i,
    input  logic                        beat_en_i,
    input  dcache_req_pkg::beat_idx_t   beat_idx_i,
    input  axi_burst_pkg::axi_r_t       r_i,
    output axi_burst_pkg::axi_ax_t      ar_o,
    output dcache_req_pkg::refill_rsp_t rsp_o
);

    dcache_req_pkg::line_addr_t addr_q;
    dcache_req_pkg::line_t      line_q;
    axi_burst_pkg::axi_resp_t   worst_q;

    always_ff @(posedge clock_i) begin
        if (capture_i) begin
            addr_q <= req_i.addr;
        end
        if (beat_en_i) begin
            line_q[beat_idx_i*`DCA_BEAT_W +: `DCA_BEAT_W] <= r_i.data;
        end
    end

    // higher code is the worse response
    always_ff @(posedge clock_i or negedge reset_i) begin
        if (!reset_i) begin
            worst_q <= axi_burst_pkg::RESP_OKAY;
        end else if (capture_i) begin
            worst_q <= axi_burst_pkg::RESP_OKAY;
        end else if (beat_en_i && (r_i.resp > worst_q)) begin
            worst_q <= r_i.resp;
        end
    end

    assign ar_o.addr  = addr_q;
    assign ar_o.len   = `DCA_BURST_LEN;
    assign ar_o.size  = `DCA_BURST_SIZE;
    assign ar_o.burst = `DCA_BURST_TYPE;

    assign rsp_o.data = line_q;   // complete one cycle after the last beat
    assign rsp_o.resp = worst_q;

endmodule

//--- rtl/evict_line_buffer.sv
`timescale 1ns/1ps
`include "dcache_axi_config.svh"

module evict_line_buffer (
    input  logic                       clock_i,
    input  logic                       capture_i,
    input  dcache_req_pkg::evict_req_t req_i,
    input  dcache_req_pkg::beat_idx_t  beat_idx_i,
    input  logic                       last_beat_i,
    input  logic                       b_en_i,
    input  axi_burst_pkg::axi_b_t      b_i,
    output axi_burst_pkg::axi_ax_t     aw_o,
    output axi_burst_pkg::axi_w_t      w_o,
    output dcache_req_pkg::evict_rsp_t rsp_o
);

    dcache_req_pkg::evict_req_t req_q;
    dcache_req_pkg::evict_rsp_t rsp_q;

    always_ff @(posedge clock_i) begin
        if (capture_i) begin
            req_q <= req_i;
        end
        if (b_en_i) begin
            rsp_q.resp <= b_i.resp;   // held for the done pulse
        end
    end

    // address phase, fixed one-line INCR burst
    assign aw_o.addr  = req_q.addr;
    assign aw_o.len   = `DCA_BURST_LEN;
    assign aw_o.size  = `DCA_BURST_SIZE;
    assign aw_o.burst = `DCA_BURST_TYPE;

    // beat 0 sits in the low bits of the line
    assign w_o.data = req_q.data[beat_idx_i*`DCA_BEAT_W +: `DCA_BEAT_W];
    assign w_o.strb = req_q.mask;
    assign w_o.last = last_beat_i;

    assign rsp_o = rsp_q;

endmodule

//--- rtl/beat_counter.sv
`timescale 1ns/1ps
`include "dcache_axi_config.svh"

module beat_counter (
    input  logic                      clock_i,
    input  logic                      reset_i,
    input  logic                      clear_i,
    input  logic                      advance_i,
    output dcache_req_pkg::beat_idx_t beat_idx_o,
    output logic                      last_beat_o
);

    dcache_req_pkg::beat_idx_t idx_q;

    always_ff @(posedge clock_i or negedge reset_i) begin
        if (!reset_i) begin
            idx_q <= '0;
        end else if (clear_i) begin
            idx_q <= '0;               // new burst
        end else if (advance_i) begin
            idx_q <= idx_q + 1'b1;     // wraps after terminal beat
        end
    end

    assign beat_idx_o  = idx_q;
    assign last_beat_o = (idx_q == dcache_req_pkg::beat_idx_t'(`DCA_BEATS - 1));

    // once the terminal beat is taken nothing moves until the next capture
    a_no_overrun: assert property (@(posedge clock_i) disable iff (!reset_i)
        advance_i && last_beat_o |=> (!advance_i until clear_i));

endmodule

//--- rtl/dcache_req_pkg.sv
`include "dcache_axi_config.svh"

package dcache_req_pkg;

    typedef logic [`DCA_ADDR_W-1:0]         line_addr_t;
    typedef logic [`DCA_BEAT_W-1:0]         beat_t;
    typedef logic [`DCA_LINE_W-1:0]         line_t;
    typedef logic [`DCA_STRB_W-1:0]         byte_mask_t;
    typedef logic [$clog2(`DCA_BEATS)-1:0]  beat_idx_t;

    typedef struct packed {
        line_addr_t addr;
    } refill_req_t;

    typedef struct packed {
        line_addr_t addr;
        line_t      data;
        byte_mask_t mask;   // same strobe on every beat
    } evict_req_t;

    typedef struct packed {
        line_t                  data;
        axi_burst_pkg::axi_resp_t resp;
    } refill_rsp_t;

    typedef struct packed {
        axi_burst_pkg::axi_resp_t resp;
    } evict_rsp_t;

    typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_e;
    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;

endpackage

//--- rtl/axi_burst_pkg.sv
`include "dcache_axi_config.svh"

package axi_burst_pkg;

    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // shared by AR and AW
    typedef struct packed {
        logic [`DCA_ADDR_W-1:0] addr;
        logic [7:0]             len;
        logic [2:0]             size;
        logic [1:0]             burst;
    } axi_ax_t;

    typedef struct packed {
        logic [`DCA_BEAT_W-1:0] data;
        logic [`DCA_STRB_W-1:0] strb;
        logic                   last;
    } axi_w_t;

    typedef struct packed {
        logic [`DCA_BEAT_W-1:0] data;
        axi_resp_t              resp;
        logic                   last;
    } axi_r_t;

    typedef struct packed {
        axi_resp_t resp;
    } axi_b_t;

endpackage

//--- rtl/dcache_axi_config.svh
`ifndef DCACHE_AXI_CONFIG_SVH
`define DCACHE_AXI_CONFIG_SVH

// bus and line geometry
`define DCA_ADDR_W      64
`define DCA_BEAT_W      64
`define DCA_LINE_W      256
`define DCA_BEATS       4
`define DCA_STRB_W      8

// fixed burst attributes, one line per burst
`define DCA_BURST_LEN   8'd3    // beats minus one
`define DCA_BURST_SIZE  3'd3    // 8 bytes per beat
`define DCA_BURST_TYPE  2'b01   // INCR
`define DCA_AXI_ID      1

`endif
